//--- verilog/dmem_config.svh
// data memory config, sizes and address alias field positions.
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// ******************************
// memory geometry
// ******************************

`define DMEM_ADDR_WIDTH 12 // byte address bits, 4 KiB.
`define DMEM_BANKS 4 // byte-wide banks, one per lane.

// ******************************
// address alias fields
// ******************************

// width code sits right above the byte address.
`define DMEM_WIDTH_LSB `DMEM_ADDR_WIDTH
`define DMEM_SIGN_BIT (`DMEM_WIDTH_LSB + 2) // load sign extension select.

`endif

//--- verilog/dmem_pkg.sv
// data memory package, access width encoding and the data vector types.
`include "dmem_config.svh"

package dmem_pkg;

  // ******************************
  // access width
  // ******************************

  // code 2'b11 is not a legal width.
  typedef enum logic [1:0] {
    BYTE     = 2'd0,
    HALFWORD = 2'd1,
    WORD     = 2'd2
  } mem_width_t;

  // ******************************
  // data and address vectors
  // ******************************

  typedef logic [7:0] byte_t; // one lane.
  typedef logic [31:0] word_t;

  typedef logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr_t; // byte address in memory.

  // one row spans all four banks.
  typedef logic [`DMEM_ADDR_WIDTH-3:0] row_addr_t;

endpackage

//--- verilog/dmem_if.sv
// data memory request and response buses between decoder, memory and extender.
`timescale 1ns/1ns

interface mem_req_if;
  import dmem_pkg::*;

  logic       valid; // one-cycle pulse, always accepted.
  logic       write;
  mem_width_t width;
  logic       sign_extend;
  dmem_addr_t addr;
  word_t      wdata;

  modport decoder (
    output valid, write, width, sign_extend, addr, wdata
  );

  modport memory (
    input valid, write, width, sign_extend, addr, wdata
  );

endinterface

interface mem_rsp_if (input logic clk);
  import dmem_pkg::*;

  // all of these line up with the bank read data.
  logic       rvalid;
  word_t      raw; // un-rotated, not yet extended.
  mem_width_t width;
  logic       sign_extend;

  modport memory (
    output rvalid, raw, width, sign_extend
  );

  modport result (
    input clk, rvalid, raw, width, sign_extend
  );

endinterface

//--- verilog/spram_block.sv
// byte-wide single-port ram bank, registered read and synchronous write.
`timescale 1ns/1ns

module spram_block (
  input  logic                clk,
  input  dmem_pkg::row_addr_t address,
  input  logic                write_enable,
  input  dmem_pkg::byte_t     data_in,
  output dmem_pkg::byte_t     data_out
);
  import dmem_pkg::*;

  localparam int ROWS = 2 ** $bits(row_addr_t);

  byte_t mem [ROWS];

  // ******************************
  // write port
  // ******************************

  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[address] <= data_in;
    end
  end

  // ******************************
  // read port
  // ******************************

  // old contents come out on a same-cycle write.
  always_ff @(posedge clk) begin
    data_out <= mem[address];
  end

endmodule

//--- verilog/apb_access_decode.sv
// apb access decoder, checks the alias fields and issues one memory request per transfer.
`timescale 1ns/1ns
`include "dmem_config.svh"

module apb_access_decode (
  input  logic            clk,
  input  logic            reset,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  dmem_pkg::word_t paddr,
  input  dmem_pkg::word_t pwdata,
  output logic            pready,
  output logic            pslverr,
  mem_req_if.decoder      req
);
  import dmem_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT
  } state_t;

  state_t     state;
  state_t     state_next;
  logic [1:0] width_code;
  logic       addr_err;
  logic       access_start;

  // ******************************
  // address alias fields
  // ******************************

  assign width_code = paddr[`DMEM_WIDTH_LSB +: 2];

  // width code 3 or any stray bit above the sign select.
  assign addr_err = (width_code == 2'b11) ||
                    (|paddr[$bits(word_t)-1:`DMEM_SIGN_BIT+1]);

  assign access_start = psel && penable && (state == IDLE); // first access cycle.

  // ******************************
  // wait state FSM
  // ******************************

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (access_start) state_next = WAIT;
      WAIT: state_next = IDLE; // master drops penable now.
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      pslverr <= 1'b0;
    end else begin
      state   <= state_next;
      pslverr <= access_start && addr_err;
    end
  end

  assign pready = (state == WAIT);

  // ******************************
  // memory request
  // ******************************

  assign req.valid       = access_start && !addr_err; // bad address never reaches banks.
  assign req.write       = pwrite;
  assign req.width       = mem_width_t'(width_code);
  assign req.sign_extend = paddr[`DMEM_SIGN_BIT];
  assign req.addr        = dmem_addr_t'(paddr);
  assign req.wdata       = pwdata;

  // a master must raise psel in setup, before penable.
  assert property (@(posedge clk) disable iff (reset) $rose(penable) |-> psel)
    else $error("penable rose without psel");

endmodule

//--- verilog/lane_steer_mem.sv
// banked data memory that steers byte lanes for any width at any byte offset.
`timescale 1ns/1ns
`include "dmem_config.svh"

module lane_steer_mem (
  input logic        clk,
  input logic        reset,
  mem_req_if.memory  req,
  mem_rsp_if.memory  rsp
);
  import dmem_pkg::*;

  logic [1:0]              offset;
  logic [1:0]              offset_q;
  row_addr_t               row;
  row_addr_t               row_next;
  logic [2:0]              lane_count;
  row_addr_t               bank_row [`DMEM_BANKS];
  logic [`DMEM_BANKS-1:0]  bank_we;
  byte_t                   bank_din [`DMEM_BANKS];
  byte_t                   bank_dout [`DMEM_BANKS];
  word_t                   raw_word;

  // ******************************
  // address split
  // ******************************

  assign offset   = req.addr[1:0];
  assign row      = req.addr[`DMEM_ADDR_WIDTH-1:2];
  assign row_next = row + 1'b1; // last row wraps to row 0.

  // bytes covered by the access.
  always_comb begin
    case (req.width)
      BYTE:     lane_count = 3'd1;
      HALFWORD: lane_count = 3'd2;
      WORD:     lane_count = 3'd4;
      default:  lane_count = 3'd0;
    endcase
  end

  // ******************************
  // banks
  // ******************************

  for (genvar b = 0; b < `DMEM_BANKS; b++) begin : g_bank
    logic [1:0] lane;

    // byte of the access word that lands in this bank.
    assign lane = 2'(b) - offset;

    // banks below the offset hold the spill into the next row.
    assign bank_row[b] = (2'(b) < offset) ? row_next : row;
    assign bank_din[b] = req.wdata[8*lane +: 8];
    assign bank_we[b]  = req.valid && req.write && ({1'b0, lane} < lane_count);

    spram_block bank (
      .clk          (clk),
      .address      (bank_row[b]),
      .write_enable (bank_we[b]),
      .data_in      (bank_din[b]),
      .data_out     (bank_dout[b])
    );
  end

  // ******************************
  // read return
  // ******************************

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp.rvalid <= 1'b0;
    end else begin
      rsp.rvalid <= req.valid && !req.write;
    end
  end

  // kept with the read so the extender sees the matching request.
  always_ff @(posedge clk) begin
    if (req.valid) begin
      offset_q        <= offset;
      rsp.width       <= req.width;
      rsp.sign_extend <= req.sign_extend;
    end
  end

  // undo the lane rotation so byte 0 comes from the offset bank.
  always_comb begin
    for (int k = 0; k < `DMEM_BANKS; k++) begin
      raw_word[8*k +: 8] = bank_dout[2'(k + offset_q)];
    end
  end

  assign rsp.raw = raw_word;

  // a store enables the lanes its width covers starting at the offset bank.
  assert property (@(posedge clk) disable iff (reset)
    (req.valid && req.write) |->
      (bank_we == 4'({2{4'((1 << (1 << req.width)) - 1)}} >> (3'd4 - offset))))
    else $error("lane enables %b do not match width %s at offset %0d",
                bank_we, req.width.name(), offset);

endmodule

//--- verilog/load_extend.sv
// load extender, trims the raw word to the access width and extends it.
`timescale 1ns/1ns

module load_extend (
  mem_rsp_if.result        rsp,
  output dmem_pkg::word_t  rdata
);
  import dmem_pkg::*;

  logic byte_fill;
  logic half_fill;

  // fill bit is the top kept bit, or zero.
  assign byte_fill = rsp.sign_extend && rsp.raw[7];
  assign half_fill = rsp.sign_extend && rsp.raw[15];

  // ******************************
  // width select
  // ******************************

  always_comb begin
    case (rsp.width)
      BYTE:     rdata = {{24{byte_fill}}, rsp.raw[7:0]};
      HALFWORD: rdata = {{16{half_fill}}, rsp.raw[15:0]};
      default:  rdata = rsp.raw; // sign choice has no effect on a word.
    endcase
  end

  // the decoder never lets an illegal width reach the banks.
  assert property (@(posedge rsp.clk)
    rsp.rvalid |-> (rsp.width inside {BYTE, HALFWORD, WORD}))
    else $error("read returned with illegal width code %b", rsp.width);

endmodule

//--- verilog/dmem_apb_top.sv
// apb data memory top, joins decoder, banked memory and load extender.
`timescale 1ns/1ns

module dmem_apb_top (
  input  logic            clk,
  input  logic            reset,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  dmem_pkg::word_t paddr,
  input  dmem_pkg::word_t pwdata,
  output dmem_pkg::word_t prdata,
  output logic            pready,
  output logic            pslverr
);

  // ******************************
  // internal buses
  // ******************************

  mem_req_if req_bus ();
  mem_rsp_if rsp_bus (.clk(clk));

  // ******************************
  // blocks
  // ******************************

  // apb side, one request per transfer.
  apb_access_decode decode (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pready  (pready),
    .pslverr (pslverr),
    .req     (req_bus.decoder)
  );

  lane_steer_mem execute (
    .clk   (clk),
    .reset (reset),
    .req   (req_bus.memory),
    .rsp   (rsp_bus.memory)
  );

  // prdata is valid in the second access cycle.
  load_extend result (
    .rsp   (rsp_bus.result),
    .rdata (prdata)
  );

endmodule

//--- bench/tb_dmem.sv
// testbench for the apb data memory that checks random transfers against a byte model.
`timescale 1ns/1ns
`include "dmem_config.svh"

module tb_dmem;
  import dmem_pkg::*;

  // transfers per test add up as 32 + 20 + 23 + 40 + 24 at four cycles each.
  localparam int XFERS       = 139;
  localparam int CYCLE_LIMIT = 4 * XFERS + 200;
  localparam int MEM_BYTES   = 2 ** `DMEM_ADDR_WIDTH;

  logic  clk;
  logic  reset;
  logic  psel;
  logic  penable;
  logic  pwrite;
  word_t paddr;
  word_t pwdata;
  word_t prdata;
  logic  pready;
  logic  pslverr;

  word_t      exp_data;
  logic       exp_err;
  byte_t      model [MEM_BYTES]; // reference copy of the memory.
  dmem_addr_t wr_addrs [16];
  integer     seed;
  int         cycle_count = 0;
  int         data_errors = 0;
  int         resp_errors = 0;
  int         proto_errors = 0;

  dmem_apb_top UUT (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ******************************
  // checks
  // ******************************

  assert property (@(posedge clk) disable iff (reset)
    (pready && !pwrite && !exp_err) |-> (prdata === exp_data))
    else begin
      data_errors++;
      $display("mismatch at %0t: prdata expected %h actual %h",
               $time, $sampled(exp_data), $sampled(prdata));
    end

  assert property (@(posedge clk) disable iff (reset) pready |-> (pslverr === exp_err))
    else begin
      resp_errors++;
      $display("mismatch at %0t: pslverr expected %b actual %b",
               $time, $sampled(exp_err), $sampled(pslverr));
    end

  // one wait state and then pready for exactly one cycle.
  assert property (@(posedge clk) disable iff (reset) $rose(penable) |-> !pready)
    else begin
      proto_errors++;
      $display("mismatch at %0t: pready expected 0 actual %b", $time, $sampled(pready));
    end

  assert property (@(posedge clk) disable iff (reset) $rose(penable) |=> pready)
    else begin
      proto_errors++;
      $display("mismatch at %0t: pready expected 1 actual %b", $time, $sampled(pready));
    end

  assert property (@(posedge clk) disable iff (reset)
    pready |-> (psel && penable && $past(penable)))
    else begin
      proto_errors++;
      $display("mismatch at %0t: pready expected 0 actual %b outside the second access cycle",
               $time, $sampled(pready));
    end

  assert property (@(posedge clk) reset |=> (!pready && !pslverr))
    else begin
      proto_errors++;
      $display("mismatch at %0t: pready expected 0 actual %b, pslverr expected 0 actual %b",
               $time, $sampled(pready), $sampled(pslverr));
    end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ******************************
  // reference model
  // ******************************

  function automatic word_t make_addr(dmem_addr_t a, logic [1:0] code, logic sgn);
    word_t addr;
    addr = '0;
    addr[`DMEM_ADDR_WIDTH-1:0] = a;
    addr[`DMEM_WIDTH_LSB +: 2] = code;
    addr[`DMEM_SIGN_BIT] = sgn;
    return addr;
  endfunction

  function automatic word_t model_read(dmem_addr_t a, logic [1:0] code, logic sgn);
    word_t w;
    int    n;
    n = (code == 2'd0) ? 1 : (code == 2'd1) ? 2 : 4;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w[8*i +: 8] = model[dmem_addr_t'(a + i)]; // wraps past the top.
    end
    if (sgn && n == 1 && w[7]) w[31:8] = '1;
    if (sgn && n == 2 && w[15]) w[31:16] = '1;
    return w;
  endfunction

  task automatic model_write(dmem_addr_t a, logic [1:0] code, word_t data);
    int n;
    n = (code == 2'd0) ? 1 : (code == 2'd1) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      model[dmem_addr_t'(a + i)] = data[8*i +: 8];
    end
  endtask

  function automatic dmem_addr_t rand_addr();
    return dmem_addr_t'($random(seed));
  endfunction

  // ******************************
  // apb driver
  // ******************************

  task automatic transfer(input logic wr, input word_t addr, input word_t data);
    logic [1:0] code;
    logic       bad;
    int         waited;
    code = addr[`DMEM_WIDTH_LSB +: 2];
    bad = (code == 2'b11) || (|(addr >> (`DMEM_SIGN_BIT + 1)));
    waited = 0;
    @(posedge clk);
    psel    <= 1'b1; // setup cycle.
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    exp_err <= bad;
    if (!wr && !bad) exp_data <= model_read(dmem_addr_t'(addr), code, addr[`DMEM_SIGN_BIT]);
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!pready) begin
      proto_errors++;
      $display("no pready for the transfer at address %h", addr);
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    if (wr && !bad) model_write(dmem_addr_t'(addr), code, data);
  endtask

  // ******************************
  // stimulus
  // ******************************

  initial begin
    dmem_addr_t a;
    word_t      d;
    word_t      bad_addr;
    seed     = 32'he278;
    reset    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    exp_data = '0;
    exp_err  = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // aligned words.
    for (int i = 0; i < 16; i++) begin
      wr_addrs[i] = rand_addr() & ~dmem_addr_t'(3);
      transfer(1'b1, make_addr(wr_addrs[i], WORD, 1'b0), $random(seed));
    end
    for (int i = 0; i < 16; i++) transfer(1'b0, make_addr(wr_addrs[i], WORD, 1'b0), '0);

    // narrow stores at each offset seen through a word read.
    for (int off = 0; off < 4; off++) begin
      a = rand_addr() & ~dmem_addr_t'(3);
      transfer(1'b1, make_addr(a, WORD, 1'b0), $random(seed));
      transfer(1'b1, make_addr(a + off, BYTE, 1'b0), $random(seed));
      transfer(1'b0, make_addr(a, WORD, 1'b0), '0);
      transfer(1'b1, make_addr(a + off, HALFWORD, 1'b0), $random(seed));
      transfer(1'b0, make_addr(a, WORD, 1'b0), '0);
    end

    // misaligned accesses crossing rows and the top of memory.
    for (int off = 1; off < 4; off++) begin
      a = (rand_addr() & ~dmem_addr_t'(3)) + off;
      transfer(1'b1, make_addr(a, WORD, 1'b0), $random(seed));
      transfer(1'b0, make_addr(a, WORD, 1'b0), '0);
      transfer(1'b1, make_addr(a, HALFWORD, 1'b0), $random(seed));
      transfer(1'b0, make_addr(a, HALFWORD, 1'b0), '0);
      a = dmem_addr_t'(MEM_BYTES - 4 + off);
      transfer(1'b1, make_addr(a, WORD, 1'b0), $random(seed));
      transfer(1'b0, make_addr(a, WORD, 1'b0), '0);
      transfer(1'b0, make_addr(dmem_addr_t'(off - 1), BYTE, 1'b0), '0); // wrapped byte.
    end
    transfer(1'b1, make_addr(dmem_addr_t'(MEM_BYTES - 1), HALFWORD, 1'b0), $random(seed));
    transfer(1'b0, make_addr(dmem_addr_t'(MEM_BYTES - 1), HALFWORD, 1'b0), '0);

    // signed and unsigned narrow loads with top bits alternately set and clear.
    for (int i = 0; i < 8; i++) begin
      a = rand_addr();
      d = $random(seed);
      d = (i % 2 == 0) ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);
      transfer(1'b1, make_addr(a, WORD, 1'b0), d);
      transfer(1'b0, make_addr(a, BYTE, 1'b1), '0);
      transfer(1'b0, make_addr(a, BYTE, 1'b0), '0);
      transfer(1'b0, make_addr(a, HALFWORD, 1'b1), '0);
      transfer(1'b0, make_addr(a, HALFWORD, 1'b0), '0);
    end

    // illegal width code or a stray high bit.
    for (int i = 0; i < 6; i++) begin
      a = rand_addr();
      transfer(1'b1, make_addr(a, WORD, 1'b0), $random(seed));
      if (i % 2 == 0) begin
        bad_addr = make_addr(a, 2'b11, 1'b0);
      end else begin
        bad_addr = make_addr(a, WORD, 1'b0) |
                   (32'h1 << (`DMEM_SIGN_BIT + 1 + ($unsigned($random(seed)) % 17)));
      end
      transfer(1'b1, bad_addr, $random(seed));
      transfer(1'b0, make_addr(a, WORD, 1'b0), '0); // must still hold the good word.
      transfer(1'b0, bad_addr, '0);
    end

    @(posedge clk);
    $display("errors: data %0d, response %0d, protocol %0d",
             data_errors, resp_errors, proto_errors);
    if (data_errors + resp_errors + proto_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/dmem_pkg.sv
verilog/dmem_if.sv
verilog/spram_block.sv
verilog/apb_access_decode.sv
verilog/lane_steer_mem.sv
verilog/load_extend.sv
verilog/dmem_apb_top.sv
bench/tb_dmem.sv
